//--- hw/idu_pkg.sv
package idu_pkg;

    // *******************************************************************
    // widths
    // *******************************************************************
    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_load      = 7'b0000011,
        opc_misc_mem  = 7'b0001111,
        opc_op_imm    = 7'b0010011,
        opc_auipc     = 7'b0010111,
        opc_op_imm_32 = 7'b0011011,
        opc_store     = 7'b0100011,
        opc_op        = 7'b0110011,
        opc_lui       = 7'b0110111,
        opc_op_32     = 7'b0111011,
        opc_branch    = 7'b1100011,
        opc_jalr      = 7'b1100111,
        opc_jal       = 7'b1101111,
        opc_system    = 7'b1110011
    } opcode_e;

    // decoded operation, funct3 and word qualify it further
    typedef enum logic [4:0] {
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_load, op_store, op_branch, op_jal, op_jalr, op_lui, op_auipc,
        op_fence, op_ecall, op_ebreak, op_mret, op_sret, op_wfi,
        op_illegal
    } op_e;

    typedef enum logic [1:0] {
        prv_u = 2'd0,
        prv_s = 2'd1,
        prv_m = 2'd3
    } priv_e;

    // mcause exception codes
    typedef enum logic [3:0] {
        cause_inst_fault      = 4'd1,
        cause_illegal         = 4'd2,
        cause_breakpoint      = 4'd3,
        cause_ecall_u         = 4'd8,
        cause_ecall_s         = 4'd9,
        cause_ecall_m         = 4'd11,
        cause_inst_page_fault = 4'd12
    } cause_e;

    // *******************************************************************
    // packets
    // *******************************************************************
    typedef struct packed {
        logic [ilen-1:0] inst;
        logic [xlen-1:0] pc;
        logic [1:0]      rresp;
    } fetch_pkt_t;

    typedef struct packed {
        priv_e priv;
        logic  tsr;
        logic  tw;
    } status_t;

    typedef struct packed {
        op_e                   op;
        logic                  word;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic                  dest_wen;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       pc;
        logic                  trap_valid;
        logic [xlen-1:0]       trap_cause;
        logic [xlen-1:0]       trap_tval;
        logic                  mret;
        logic                  sret;
    } decode_pkt_t;

endpackage

//--- hw/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder
    import idu_pkg::*;
(
    input  fetch_pkt_t  fetch,
    output decode_pkt_t pkt
);

    logic [ilen-1:0] inst;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    opcode_e         opcode;
    op_e             alu_op;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic            shift_ok64, shift_ok32, reg_ok;
    logic            use_rs1, use_rs2;

    assign inst   = fetch.inst;
    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];
    assign opcode = opcode_e'(inst[6:0]);

    // sign extended immediates per format
    assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'h000};
    assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // encoding checks for shifts and register ops
    assign shift_ok64 = inst[31:26] == 6'b000000 ||
                        (funct3 == 3'b101 && inst[31:26] == 6'b010000);
    assign shift_ok32 = funct7 == 7'b0000000 ||
                        (funct3 == 3'b101 && funct7 == 7'b0100000);
    assign reg_ok     = funct7 == 7'b0000000 ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    // funct3 to alu op, bit 30 selects arithmetic shift
    always_comb begin
        case (funct3)
            3'b000:  alu_op = op_add;
            3'b001:  alu_op = op_sll;
            3'b010:  alu_op = op_slt;
            3'b011:  alu_op = op_sltu;
            3'b100:  alu_op = op_xor;
            3'b101:  alu_op = inst[30] ? op_sra : op_srl;
            3'b110:  alu_op = op_or;
            default: alu_op = op_and;
        endcase
    end

    // *******************************************************************
    // main decode
    // *******************************************************************
    always_comb begin
        pkt        = '0;
        pkt.op     = op_illegal;
        pkt.funct3 = funct3;
        pkt.rd     = inst[11:7];
        pkt.pc     = fetch.pc;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        case (opcode)
            opc_lui: begin
                pkt.op       = op_lui;
                pkt.imm      = imm_u;
                pkt.dest_wen = 1'b1;
            end
            opc_auipc: begin
                pkt.op       = op_auipc;
                pkt.imm      = imm_u;
                pkt.dest_wen = 1'b1;
            end
            opc_jal: begin
                pkt.op       = op_jal;
                pkt.imm      = imm_j;
                pkt.dest_wen = 1'b1;
            end
            opc_jalr: begin
                if (funct3 == 3'b000) pkt.op = op_jalr;
                pkt.imm      = imm_i;
                pkt.dest_wen = 1'b1;
                use_rs1      = 1'b1;
            end
            opc_branch: begin
                if (funct3[2:1] != 2'b01) pkt.op = op_branch;
                pkt.imm = imm_b;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            opc_load: begin
                // lb lh lw ld lbu lhu lwu
                if (funct3 != 3'b111) pkt.op = op_load;
                pkt.imm      = imm_i;
                pkt.dest_wen = 1'b1;
                use_rs1      = 1'b1;
            end
            opc_store: begin
                if (!funct3[2]) pkt.op = op_store;
                pkt.imm = imm_s;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            opc_op_imm, opc_op_imm_32: begin
                pkt.word     = opcode == opc_op_imm_32;
                pkt.imm      = imm_i;
                pkt.dest_wen = 1'b1;
                use_rs1      = 1'b1;
                if (!pkt.word && (funct3[1:0] != 2'b01 || shift_ok64))
                    pkt.op = alu_op;
                if (pkt.word && (funct3 == 3'b000 || (funct3[1:0] == 2'b01 && shift_ok32)))
                    pkt.op = alu_op;
            end
            opc_op, opc_op_32: begin
                pkt.word     = opcode == opc_op_32;
                pkt.dest_wen = 1'b1;
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                if (reg_ok && (!pkt.word || funct3 == 3'b000 || funct3[1:0] == 2'b01))
                    pkt.op = (funct3 == 3'b000 && inst[30]) ? op_sub : alu_op;
            end
            opc_misc_mem: begin
                if (funct3 == 3'b000) pkt.op = op_fence;
            end
            opc_system: begin
                // no csr support, only full-word system encodings
                case (inst)
                    32'h0000_0073: pkt.op = op_ecall;
                    32'h0010_0073: pkt.op = op_ebreak;
                    32'h1050_0073: pkt.op = op_wfi;
                    32'h3020_0073: begin
                        pkt.op   = op_mret;
                        pkt.mret = 1'b1;
                    end
                    32'h1020_0073: begin
                        pkt.op   = op_sret;
                        pkt.sret = 1'b1;
                    end
                    default: pkt.op = op_illegal;
                endcase
            end
            default: pkt.op = op_illegal;
        endcase

        // an unknown encoding carries no operands or writeback
        if (pkt.op == op_illegal) begin
            pkt.dest_wen = 1'b0;
            pkt.word     = 1'b0;
            pkt.imm      = '0;
            use_rs1      = 1'b0;
            use_rs2      = 1'b0;
        end
        pkt.rs1 = use_rs1 ? inst[19:15] : '0;
        pkt.rs2 = use_rs2 ? inst[24:20] : '0;
    end

endmodule

//--- hw/trap_check.sv
`timescale 1ns/100ps

module trap_check
    import idu_pkg::*;
(
    input  decode_pkt_t raw,
    input  fetch_pkt_t  fetch,
    input  status_t     status,
    output decode_pkt_t pkt
);

    logic   below_m;
    logic   illegal;
    logic   fetch_err;
    logic   trap;
    cause_e cause;

    assign below_m   = status.priv != prv_m;
    // rresp 2 and 3 are the fetch error responses
    assign fetch_err = fetch.rresp[1];

    // privilege checks for the return and wait instructions
    assign illegal = raw.op == op_illegal ||
                     (raw.mret && below_m) ||
                     (raw.sret && status.priv == prv_u) ||
                     (raw.sret && status.priv == prv_s && status.tsr) ||
                     (raw.op == op_wfi && below_m && status.tw);

    assign trap = fetch_err || illegal || raw.op == op_ecall || raw.op == op_ebreak;

    // cause priority, page fault first
    always_comb begin
        if (fetch.rresp == 2'd2)         cause = cause_inst_page_fault;
        else if (illegal)                cause = cause_illegal;
        else if (raw.op == op_ebreak)    cause = cause_breakpoint;
        else if (fetch.rresp == 2'd3)    cause = cause_inst_fault;
        else if (status.priv == prv_u)   cause = cause_ecall_u;
        else if (status.priv == prv_s)   cause = cause_ecall_s;
        else                             cause = cause_ecall_m;
    end

    always_comb begin
        pkt            = raw;
        pkt.trap_valid = trap;
        pkt.trap_cause = trap ? {{(xlen-4){1'b0}}, cause} : '0;
        if (fetch_err || raw.op == op_ebreak)
            pkt.trap_tval = fetch.pc;
        else if (illegal)
            pkt.trap_tval = {{(xlen-ilen){1'b0}}, fetch.inst};
        else
            pkt.trap_tval = '0;
    end

endmodule

//--- hw/decode_reg.sv
`timescale 1ns/100ps

module decode_reg
    import idu_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  decode_pkt_t in_pkt,
    input  logic        inst_valid,
    input  logic        ex_ready,
    input  logic        ex_flush,
    output logic        inst_ready,
    output logic        decode_valid,
    output decode_pkt_t out_pkt,
    output logic        if_flush
);

    logic held_trap;
    logic slot_free;

    // trap, mret or sret waiting in the register redirects fetch
    assign held_trap = decode_valid && (out_pkt.trap_valid || out_pkt.mret || out_pkt.sret);

    // empty, or the current packet leaves this cycle
    assign slot_free = ex_ready || !decode_valid;

    assign inst_ready = inst_valid && slot_free && !ex_flush && !held_trap;
    assign if_flush   = ex_flush || held_trap;

    // *******************************************************************
    // valid flop and packet register
    // *******************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decode_valid <= 1'b0;
        end else if (ex_flush) begin
            decode_valid <= 1'b0;
        end else if (slot_free) begin
            decode_valid <= inst_ready;
        end
    end

    // holds under back-pressure since inst_ready is low then
    always_ff @(posedge clk) begin
        if (inst_ready) begin
            out_pkt <= in_pkt;
        end
    end

endmodule

//--- hw/operand_select.sv
`timescale 1ns/100ps

module operand_select
    import idu_pkg::*;
(
    input  decode_pkt_t     pkt,
    output logic [xlen-1:0] operand1,
    output logic [xlen-1:0] operand2,
    output logic [xlen-1:0] next_pc
);

    // link address and pc relative ops use the pc
    always_comb begin
        case (pkt.op)
            op_auipc, op_jal, op_jalr: operand1 = pkt.pc;
            default:                   operand1 = '0;
        endcase
    end

    // register forms of the alu ops carry a zero immediate
    always_comb begin
        case (pkt.op)
            op_jal, op_jalr:
                operand2 = xlen'(4);
            op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra, op_or, op_and,
            op_lui, op_auipc, op_load, op_store:
                operand2 = pkt.imm;
            default:
                operand2 = '0;
        endcase
    end

    assign next_pc = pkt.pc + xlen'(4);

endmodule

//--- hw/idu_top.sv
`timescale 1ns/100ps

module idu_top
    import idu_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  fetch_pkt_t      fetch,
    input  logic            inst_valid,
    output logic            inst_ready,
    input  status_t         status,
    input  logic            ex_ready,
    input  logic            ex_flush,
    output logic            decode_valid,
    output decode_pkt_t     decode,
    output logic [xlen-1:0] operand1,
    output logic [xlen-1:0] operand2,
    output logic [xlen-1:0] next_pc,
    output logic            if_flush
);

    decode_pkt_t raw_pkt;
    decode_pkt_t chk_pkt;

    inst_decoder u_decoder (
        .fetch (fetch),
        .pkt   (raw_pkt)
    );

    trap_check u_trap_check (
        .raw    (raw_pkt),
        .fetch  (fetch),
        .status (status),
        .pkt    (chk_pkt)
    );

    decode_reg u_decode_reg (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_pkt       (chk_pkt),
        .inst_valid   (inst_valid),
        .ex_ready     (ex_ready),
        .ex_flush     (ex_flush),
        .inst_ready   (inst_ready),
        .decode_valid (decode_valid),
        .out_pkt      (decode),
        .if_flush     (if_flush)
    );

    operand_select u_operand_select (
        .pkt      (decode),
        .operand1 (operand1),
        .operand2 (operand2),
        .next_pc  (next_pc)
    );

endmodule

//--- tb/idu_ref.svh
`ifndef IDU_REF_SVH
`define IDU_REF_SVH

// *******************************************************************
// instruction encoders, one per base format
// *******************************************************************
function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

// bit 0 of the branch and jump offsets is not encoded
function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [6:0] opc);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
endfunction

// alu op from funct3, sub only for the register form
function automatic op_e alu_ref(logic [2:0] f3, logic b30, logic is_reg);
    case (f3)
        3'd0:    return (is_reg && b30) ? op_sub : op_add;
        3'd1:    return op_sll;
        3'd2:    return op_slt;
        3'd3:    return op_sltu;
        3'd4:    return op_xor;
        3'd5:    return b30 ? op_sra : op_srl;
        3'd6:    return op_or;
        default: return op_and;
    endcase
endfunction

// *******************************************************************
// reference decode with trap fields
// *******************************************************************
function automatic decode_pkt_t ref_decode(fetch_pkt_t f, status_t s);
    logic [31:0] i;
    decode_pkt_t p;
    logic        ill;
    i        = f.inst;
    p        = '0;
    p.op     = op_illegal;
    p.funct3 = i[14:12];
    p.rd     = i[11:7];
    p.pc     = f.pc;
    case (i[6:0])
        7'h37, 7'h17: begin
            p.op       = (i[6:0] == 7'h37) ? op_lui : op_auipc;
            p.imm      = {{32{i[31]}}, i[31:12], 12'h000};
            p.dest_wen = 1'b1;
        end
        7'h6f: begin
            p.op       = op_jal;
            p.imm      = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            p.dest_wen = 1'b1;
        end
        7'h67, 7'h03: begin
            p.op       = (i[6:0] == 7'h67) ? op_jalr : op_load;
            p.imm      = {{52{i[31]}}, i[31:20]};
            p.dest_wen = 1'b1;
            p.rs1      = i[19:15];
        end
        7'h63: begin
            p.op  = op_branch;
            p.imm = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            p.rs1 = i[19:15];
            p.rs2 = i[24:20];
        end
        7'h23: begin
            p.op  = op_store;
            p.imm = {{52{i[31]}}, i[31:25], i[11:7]};
            p.rs1 = i[19:15];
            p.rs2 = i[24:20];
        end
        7'h13, 7'h1b: begin
            p.op       = alu_ref(i[14:12], i[30], 1'b0);
            p.word     = i[3];
            p.imm      = {{52{i[31]}}, i[31:20]};
            p.dest_wen = 1'b1;
            p.rs1      = i[19:15];
        end
        7'h33, 7'h3b: begin
            p.op       = alu_ref(i[14:12], i[30], 1'b1);
            p.word     = i[3];
            p.dest_wen = 1'b1;
            p.rs1      = i[19:15];
            p.rs2      = i[24:20];
        end
        7'h0f: p.op = op_fence;
        7'h73: begin
            case (i)
                32'h0000_0073: p.op = op_ecall;
                32'h0010_0073: p.op = op_ebreak;
                32'h1050_0073: p.op = op_wfi;
                32'h3020_0073: p.op = op_mret;
                32'h1020_0073: p.op = op_sret;
                default:       p.op = op_illegal;
            endcase
        end
        default: p.op = op_illegal;
    endcase
    p.mret = p.op == op_mret;
    p.sret = p.op == op_sret;

    ill = p.op == op_illegal ||
          (p.mret && s.priv != prv_m) ||
          (p.sret && (s.priv == prv_u || (s.priv == prv_s && s.tsr))) ||
          (p.op == op_wfi && s.priv != prv_m && s.tw);
    p.trap_valid = f.rresp[1] || ill || p.op == op_ecall || p.op == op_ebreak;
    if (!p.trap_valid)         p.trap_cause = 64'd0;
    else if (f.rresp == 2'd2)  p.trap_cause = 64'd12;
    else if (ill)              p.trap_cause = 64'd2;
    else if (p.op == op_ebreak) p.trap_cause = 64'd3;
    else if (f.rresp == 2'd3)  p.trap_cause = 64'd1;
    else if (s.priv == prv_u)  p.trap_cause = 64'd8;
    else if (s.priv == prv_s)  p.trap_cause = 64'd9;
    else                       p.trap_cause = 64'd11;
    if (f.rresp[1] || p.op == op_ebreak) p.trap_tval = f.pc;
    else if (ill)                        p.trap_tval = {32'h0, i};
    else                                 p.trap_tval = 64'd0;
    return p;
endfunction

`endif

//--- tb/idu_tb.sv
`timescale 1ns/100ps

module idu_tb
    import idu_pkg::*;
;

    `include "idu_ref.svh"

    localparam int n_stim = 640;

    typedef struct packed {
        decode_pkt_t     pkt;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        logic [xlen-1:0] npc;
    } expect_t;

    logic            clk;
    logic            arst_n;
    fetch_pkt_t      fetch;
    logic            inst_valid;
    logic            inst_ready;
    status_t         status;
    logic            ex_ready;
    logic            ex_flush;
    logic            decode_valid;
    decode_pkt_t     decode;
    logic [xlen-1:0] operand1;
    logic [xlen-1:0] operand2;
    logic [xlen-1:0] next_pc;
    logic            if_flush;

    integer      seed = 32'h598ae90d;
    int          ex_mode;
    int          errors;
    int          checks;
    int          tests;
    int          test_err0;
    string       cur_test;
    expect_t     exp_q[$];
    expect_t     mon_exp;
    logic        mon_held;
    logic        prev_flush;
    logic        prev_hold;
    decode_pkt_t prev_pkt;

    idu_top dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch        (fetch),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .status       (status),
        .ex_ready     (ex_ready),
        .ex_flush     (ex_flush),
        .decode_valid (decode_valid),
        .decode       (decode),
        .operand1     (operand1),
        .operand2     (operand2),
        .next_pc      (next_pc),
        .if_flush     (if_flush)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // *******************************************************************
    // reference and checks
    // *******************************************************************
    function automatic expect_t expected_out(fetch_pkt_t f, status_t s);
        expect_t e;
        e.pkt = ref_decode(f, s);
        e.op1 = (e.pkt.op inside {op_auipc, op_jal, op_jalr}) ? f.pc : 64'd0;
        if (e.pkt.op inside {op_jal, op_jalr})
            e.op2 = 64'd4;
        else if (e.pkt.op inside {op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl,
                                  op_sra, op_or, op_and, op_lui, op_auipc, op_load, op_store})
            e.op2 = e.pkt.imm;
        else
            e.op2 = 64'd0;
        e.npc = f.pc + 64'd4;
        return e;
    endfunction

    task automatic check(string what, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_out(expect_t e);
        check("op", 64'(e.pkt.op), 64'(decode.op));
        check("word", 64'(e.pkt.word), 64'(decode.word));
        check("funct3", 64'(e.pkt.funct3), 64'(decode.funct3));
        check("rd", 64'(e.pkt.rd), 64'(decode.rd));
        check("rs1", 64'(e.pkt.rs1), 64'(decode.rs1));
        check("rs2", 64'(e.pkt.rs2), 64'(decode.rs2));
        check("dest_wen", 64'(e.pkt.dest_wen), 64'(decode.dest_wen));
        check("imm", e.pkt.imm, decode.imm);
        check("pc", e.pkt.pc, decode.pc);
        check("trap_valid", 64'(e.pkt.trap_valid), 64'(decode.trap_valid));
        check("trap_cause", e.pkt.trap_cause, decode.trap_cause);
        check("trap_tval", e.pkt.trap_tval, decode.trap_tval);
        check("mret", 64'(e.pkt.mret), 64'(decode.mret));
        check("sret", 64'(e.pkt.sret), 64'(decode.sret));
        check("operand1", e.op1, operand1);
        check("operand2", e.op2, operand2);
        check("next_pc", e.npc, next_pc);
    endtask

    // sampled before the flops update, so one view of the edge
    always @(posedge clk) begin
        if (arst_n) begin
            mon_held = decode_valid && (decode.trap_valid || decode.mret || decode.sret);
            check("if_flush", 64'(ex_flush || mon_held), 64'(if_flush));
            check("inst_ready", 64'(inst_valid && (ex_ready || !decode_valid) && !ex_flush &&
                  !mon_held), 64'(inst_ready));
            if (prev_flush)
                check("valid after flush", 64'd0, 64'(decode_valid));
            if (prev_hold && decode_valid)
                check("held packet stable", 64'd1, 64'(decode === prev_pkt));
            if (decode_valid && (ex_flush || ex_ready)) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: decode output with no instruction accepted", cur_test);
                end else begin
                    mon_exp = exp_q.pop_front();
                    // a flushed packet is dropped unchecked
                    if (!ex_flush)
                        compare_out(mon_exp);
                end
            end
            if (inst_valid && inst_ready)
                exp_q.push_back(expected_out(fetch, status));
            prev_flush = ex_flush;
            prev_hold  = decode_valid && !ex_ready && !ex_flush;
            prev_pkt   = decode;
        end
    end

    always @(negedge clk) begin
        case (ex_mode)
            0:       ex_ready = 1'b1;
            1:       ex_ready = ($random(seed) % 4) != 0;
            default: ex_ready = 1'b0;
        endcase
    end

    // *******************************************************************
    // stimulus helpers
    // *******************************************************************
    function automatic status_t mk_status(int p, logic tsr, logic tw);
        status_t s;
        s.priv = (p == 0) ? prv_u : (p == 1) ? prv_s : prv_m;
        s.tsr  = tsr;
        s.tw   = tw;
        return s;
    endfunction

    // entered and left at a falling edge
    task automatic send_inst(logic [31:0] inst, logic [1:0] rresp, status_t st);
        logic [31:0] hi;
        logic [31:0] lo;
        hi          = $random(seed);
        lo          = $random(seed);
        fetch.inst  = inst;
        fetch.pc    = {hi, lo[31:2], 2'b00};
        fetch.rresp = rresp;
        status      = st;
        inst_valid  = 1'b1;
        do @(posedge clk); while (!inst_ready);
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic rand_inst(int kind, output logic [31:0] inst);
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = $random(seed);
        r2 = $random(seed);
        f3 = r[17:15];
        if (kind == 8 || kind == 10)
            f3 = (r[16:15] == 2'd0) ? 3'd0 : (r[16:15] == 2'd1) ? 3'd1 : 3'd5;
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && r2[0]) ? 7'h20 : 7'h00;
        case (kind)
            0:  inst = enc_u(r2[19:0], r[4:0], 7'h37);
            1:  inst = enc_u(r2[19:0], r[4:0], 7'h17);
            2:  inst = enc_j(r2[20:0], r[4:0], 7'h6f);
            3:  inst = enc_i(r2[11:0], r[9:5], 3'd0, r[4:0], 7'h67);
            4:  inst = enc_b(r2[12:0], r[14:10], r[9:5], {f3[2] | (f3[2:1] == 2'b01), f3[1:0]},
                             7'h63);
            5:  inst = enc_i(r2[11:0], r[9:5], (f3 == 3'd7) ? 3'd6 : f3, r[4:0], 7'h03);
            6:  inst = enc_s(r2[11:0], r[14:10], r[9:5], {1'b0, f3[1:0]}, 7'h23);
            7: begin
                if (f3 == 3'd1)
                    inst = enc_i({6'd0, r2[5:0]}, r[9:5], f3, r[4:0], 7'h13);
                else if (f3 == 3'd5)
                    inst = enc_i({1'b0, r2[10], 4'd0, r2[5:0]}, r[9:5], f3, r[4:0], 7'h13);
                else
                    inst = enc_i(r2[11:0], r[9:5], f3, r[4:0], 7'h13);
            end
            8: begin
                if (f3 == 3'd0)
                    inst = enc_i(r2[11:0], r[9:5], f3, r[4:0], 7'h1b);
                else
                    inst = enc_i({1'b0, f3[2] & r2[10], 5'd0, r2[4:0]}, r[9:5], f3, r[4:0],
                                 7'h1b);
            end
            9:  inst = enc_r(f7, r[14:10], r[9:5], f3, r[4:0], 7'h33);
            10: inst = enc_r(f7, r[14:10], r[9:5], f3, r[4:0], 7'h3b);
            11: inst = enc_i(r2[11:0], r[9:5], 3'd0, r[4:0], 7'h0f);
            12: begin
                case (r2[2:0])
                    3'd0:    inst = 32'h0000_0073;
                    3'd1:    inst = 32'h0010_0073;
                    3'd2:    inst = 32'h1050_0073;
                    3'd3:    inst = 32'h3020_0073;
                    default: inst = 32'h1020_0073;
                endcase
            end
            // custom-0 opcode, never decoded
            default: inst = {r2[24:0], 7'h0b};
        endcase
    endtask

    task automatic send_random(int kind, logic faults);
        logic [31:0] inst;
        logic [31:0] r;
        r = $random(seed);
        rand_inst(kind, inst);
        send_inst(inst, (faults && r[2:0] == 3'd0) ? {1'b1, r[3]} : 2'd0,
                  mk_status(int'(r[9:8]) % 3, r[4], r[5]));
    endtask

    task automatic start_test(string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic finish_test();
        inst_valid = 1'b0;
        while (decode_valid) @(negedge clk);
        // register drained, so every accepted instruction has been seen
        check("queue empty", 64'd0, 64'(exp_q.size()));
        exp_q.delete();
        tests++;
        $display("test %s done, %0d errors", cur_test, errors - test_err0);
    endtask

    initial begin
        repeat (n_stim * 20 + 10) @(posedge clk);
        $display("timeout: the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    // *******************************************************************
    // test sequence
    // *******************************************************************
    initial begin
        arst_n     = 1'b0;
        fetch      = '0;
        inst_valid = 1'b0;
        status     = mk_status(3, 1'b0, 1'b0);
        ex_ready   = 1'b1;
        ex_flush   = 1'b0;
        ex_mode    = 0;
        prev_flush = 1'b0;
        prev_hold  = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("random_decode");
        repeat (300) send_random(int'($unsigned($random(seed)) % 14), 1'b1);
        finish_test();

        start_test("operands");
        for (int n = 0; n < 60; n++) send_random((n % 5 == 4) ? 7 : n % 5, 1'b0);
        finish_test();

        start_test("privileged");
        for (int p = 0; p < 3; p++) begin
            for (int t = 0; t < 4; t++) begin
                send_inst(32'h3020_0073, 2'd0, mk_status(p, t[1], t[0]));
                send_inst(32'h1020_0073, 2'd0, mk_status(p, t[1], t[0]));
                send_inst(32'h1050_0073, 2'd0, mk_status(p, t[1], t[0]));
            end
        end
        repeat (20) send_random(13, 1'b0);
        finish_test();

        start_test("exceptions");
        for (int p = 0; p < 3; p++) send_inst(32'h0000_0073, 2'd0, mk_status(p, 1'b0, 1'b0));
        send_inst(32'h0010_0073, 2'd0, mk_status(1, 1'b0, 1'b0));
        send_inst(32'h0000_0013, 2'd2, mk_status(0, 1'b0, 1'b0));
        send_inst(32'h0000_0013, 2'd3, mk_status(3, 1'b0, 1'b0));
        send_inst(32'h0000_000b, 2'd2, mk_status(1, 1'b0, 1'b0));
        finish_test();

        start_test("backpressure");
        ex_mode = 1;
        repeat (200) send_random(int'($unsigned($random(seed)) % 12), 1'b0);
        finish_test();
        ex_mode = 0;

        start_test("flush");
        for (int n = 0; n < 4; n++) begin
            ex_mode = 2;
            send_random(n, 1'b0);
            @(negedge clk);
            ex_flush = 1'b1;
            @(negedge clk);
            ex_flush = 1'b0;
            ex_mode  = 0;
        end
        // trap held at the output blocks the next instruction
        ex_mode = 2;
        send_inst(32'h0000_0073, 2'd0, mk_status(0, 1'b0, 1'b0));
        fork
            send_inst(32'h0000_0013, 2'd0, mk_status(3, 1'b0, 1'b0));
            begin
                repeat (4) @(negedge clk);
                ex_mode = 0;
            end
        join
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+tb
hw/idu_pkg.sv
hw/inst_decoder.sv
hw/trap_check.sv
hw/decode_reg.sv
hw/operand_select.sv
hw/idu_top.sv
tb/idu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module idu_tb -o idu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/idu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
exit 1
